/* common/ex_defs.svh */
// Execute stage parameters

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Width of a data word and of the ALU operands
`define EX_XLEN 32

// Register file address width
`define EX_RF_AW 5

//////////////////////////////
// Multiplier sequencing
//////////////////////////////

// One shift-add step per multiplier bit
`define EX_MULT_STEPS `EX_XLEN

// Step counter width that holds EX_MULT_STEPS
`define EX_CNT_W 6

`endif

/* common/ex_pkg.sv */
// Execute stage types

`include "ex_defs.svh"

package ex_pkg;

  //////////////////////////////
  // Basic types
  //////////////////////////////

  // Data word
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // Register file address
  typedef logic [`EX_RF_AW-1:0] rf_addr_t;

  //////////////////////////////
  // Opcodes and states
  //////////////////////////////

  // ALU operations with the branch comparisons last
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiply operations
  // Low word, signed high word, unsigned high word
  typedef enum logic [1:0] {
    MULT_MUL   = 2'd0,
    MULT_MULH  = 2'd1,
    MULT_MULHU = 2'd2
  } mult_op_e;

  // Multiplier sequencer states
  typedef enum logic [1:0] {
    MULT_IDLE = 2'd0,
    MULT_BUSY = 2'd1,
    MULT_DONE = 2'd2
  } mult_state_e;

  //////////////////////////////
  // Pipe and side-band structs
  //////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic     instr_valid;
    xlen_t    pc;
    logic     alu_en;
    alu_op_e  alu_op;
    logic     mult_en;
    mult_op_e mult_op;
    xlen_t    operand_a;
    xlen_t    operand_b;
    xlen_t    operand_c;     // Branch target
    logic     rf_we;
    rf_addr_t rf_waddr;
    logic     branch_in_ex;
  } id_ex_pipe_t;

  // Execute to writeback
  typedef struct packed {
    logic     instr_valid;
    logic     rf_we;
    rf_addr_t rf_waddr;
    xlen_t    rf_wdata;
    xlen_t    pc;
  } ex_wb_pipe_t;

  // Same-cycle forwarding back to decode
  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    xlen_t    wdata;
  } rf_fwd_t;

  // Branch decision and target to fetch
  typedef struct packed {
    logic  decision;
    xlen_t target;
  } branch_t;

endpackage

/* alu/ex_alu.sv */
// Execute stage ALU

`timescale 1ns/1ps

`include "ex_defs.svh"

module ex_alu
(
  input  ex_pkg::alu_op_e       operator_i,
  input  logic [`EX_XLEN-1:0]   operand_a_i,
  input  logic [`EX_XLEN-1:0]   operand_b_i,
  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  cmp_result_o
);

  // Shift amount comes from the low bits of operand b
  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic [`EX_XLEN-1:0] sum;
  logic [`EX_XLEN-1:0] diff;
  logic [SHAMT_W-1:0]  shamt;
  logic                is_equal;
  logic                lt_signed;
  logic                lt_unsigned;

  //////////////////////////////
  // Shared arithmetic
  //////////////////////////////

  assign sum   = operand_a_i + operand_b_i;
  assign diff  = operand_a_i - operand_b_i;
  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Comparisons reused by set-less-than and branches
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_unsigned = (operand_a_i < operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));

  //////////////////////////////
  // Compare result
  //////////////////////////////

  always_comb
  begin
    unique case (operator_i)
      ex_pkg::ALU_EQ:  cmp_result_o = is_equal;
      ex_pkg::ALU_NE:  cmp_result_o = !is_equal;
      ex_pkg::ALU_LT:  cmp_result_o = lt_signed;
      ex_pkg::ALU_GE:  cmp_result_o = !lt_signed;
      ex_pkg::ALU_LTU: cmp_result_o = lt_unsigned;
      ex_pkg::ALU_GEU: cmp_result_o = !lt_unsigned;
      // Not a branch comparison
      default:         cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result mux
  //////////////////////////////

  always_comb
  begin
    unique case (operator_i)
      ex_pkg::ALU_ADD:  result_o = sum;
      ex_pkg::ALU_SUB:  result_o = diff;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
      ex_pkg::ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
      // Branch comparisons return the flag zero-extended
      default:          result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

/* mult/mult_ctrl.sv */
// Multiplier sequencer

`timescale 1ns/1ps

module mult_ctrl
(
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic ex_ready_i,
  input  logic last_i,
  output logic load_o,
  output logic step_o,
  output logic ready_o
);

  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_state_e state_d;

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////

  always_comb
  begin
    state_d = state_q;
    load_o  = 1'b0;
    step_o  = 1'b0;
    ready_o = 1'b0;
    unique case (state_q)
      ex_pkg::MULT_IDLE:
      begin
        // Ready for anything but a new multiply
        ready_o = !start_i;
        if (start_i)
        begin
          load_o  = 1'b1;
          state_d = ex_pkg::MULT_BUSY;
        end
      end
      ex_pkg::MULT_BUSY:
      begin
        // One shift-add step per cycle
        step_o = 1'b1;
        if (last_i)
          state_d = ex_pkg::MULT_DONE;
      end
      ex_pkg::MULT_DONE:
      begin
        // Hold the product until the stage hands it on
        ready_o = 1'b1;
        if (ex_ready_i)
          state_d = ex_pkg::MULT_IDLE;
      end
      default: state_d = ex_pkg::MULT_IDLE;
    endcase
  end

  // State register
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ex_pkg::MULT_IDLE;
    else
      state_q <= state_d;
  end

endmodule

/* mult/mult_step_counter.sv */
// Multiplier step counter

`timescale 1ns/1ps

`include "ex_defs.svh"

module mult_step_counter
(
  input  logic clk,
  input  logic rst_n,
  input  logic load_i,
  input  logic step_i,
  output logic last_o
);

  logic [`EX_CNT_W-1:0] cnt_q;

  // Load the full step count, then count down once per step
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else if (load_i)
      cnt_q <= `EX_CNT_W'(`EX_MULT_STEPS);
    else if (step_i)
      cnt_q <= cnt_q - `EX_CNT_W'(1);
  end

  // Count of one marks the final step
  assign last_o = (cnt_q == `EX_CNT_W'(1));

endmodule

/* mult/mult_datapath.sv */
// Shift-add multiplier datapath

`timescale 1ns/1ps

`include "ex_defs.svh"

module mult_datapath
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load_i,
  input  logic                step_i,
  input  ex_pkg::mult_op_e    op_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  output logic [`EX_XLEN-1:0] result_o
);

  localparam int XL = `EX_XLEN;

  logic                signed_mode;
  logic [XL-1:0]       mag_a;
  logic [XL-1:0]       mag_b;
  logic [2*XL-1:0]     acc_q;
  logic [2*XL-1:0]     mcand_q;
  logic [XL-1:0]       mplier_q;
  logic                neg_q;
  ex_pkg::mult_op_e    op_q;
  logic [2*XL-1:0]     product;

  //////////////////////////////
  // Operand magnitudes
  //////////////////////////////

  // Only the signed high word needs sign handling
  assign signed_mode = (op_i == ex_pkg::MULT_MULH);
  assign mag_a = (signed_mode && op_a_i[XL-1]) ? -op_a_i : op_a_i;
  assign mag_b = (signed_mode && op_b_i[XL-1]) ? -op_b_i : op_b_i;

  //////////////////////////////
  // Shift-add registers
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_q    <= '0;
      mcand_q  <= '0;
      mplier_q <= '0;
      neg_q    <= 1'b0;
      op_q     <= ex_pkg::MULT_MUL;
    end
    else if (load_i)
    begin
      acc_q    <= '0;
      mcand_q  <= {{XL{1'b0}}, mag_a};
      mplier_q <= mag_b;
      // Product is negative when exactly one signed operand is
      neg_q    <= signed_mode && (op_a_i[XL-1] ^ op_b_i[XL-1]);
      op_q     <= op_i;
    end
    else if (step_i)
    begin
      // Add the shifted multiplicand for each set multiplier bit
      if (mplier_q[0])
        acc_q <= acc_q + mcand_q;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Restore the sign, then pick the requested word
  assign product  = neg_q ? -acc_q : acc_q;
  assign result_o = (op_q == ex_pkg::MULT_MUL) ? product[XL-1:0] : product[2*XL-1:XL];

endmodule

/* src/ex_stage.sv */
// Execute stage top level

`timescale 1ns/1ps

module ex_stage
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                kill_ex_i,
  input  ex_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  logic                wb_ready_i,
  output logic                ex_ready_o,
  output logic                ex_valid_o,
  output ex_pkg::ex_wb_pipe_t ex_wb_pipe_o,
  output ex_pkg::rf_fwd_t     fwd_o,
  output ex_pkg::branch_t     branch_o
);

  ex_pkg::xlen_t    alu_result;
  ex_pkg::xlen_t    mult_result;
  ex_pkg::xlen_t    wdata;
  logic             alu_cmp_result;
  logic             alu_en_gated;
  logic             mult_en_gated;
  logic             rf_we_gated;
  logic             branch_valid;
  logic             mult_load;
  logic             mult_step;
  logic             mult_last;
  logic             mult_ready;
  // EX/WB register fields
  logic             wb_valid_q;
  logic             wb_we_q;
  ex_pkg::rf_addr_t wb_waddr_q;
  ex_pkg::xlen_t    wb_wdata_q;
  ex_pkg::xlen_t    wb_pc_q;

  // Enables only count for a valid, live instruction
  assign alu_en_gated  = id_ex_pipe_i.alu_en && id_ex_pipe_i.instr_valid && !kill_ex_i;
  assign mult_en_gated = id_ex_pipe_i.mult_en && id_ex_pipe_i.instr_valid && !kill_ex_i;
  assign rf_we_gated   = id_ex_pipe_i.rf_we && id_ex_pipe_i.instr_valid && !kill_ex_i;
  assign branch_valid  = id_ex_pipe_i.branch_in_ex && id_ex_pipe_i.instr_valid;

  //////////////////////////////
  // Write data and forwarding
  //////////////////////////////

  always_comb
  begin
    wdata = '0;
    if (alu_en_gated)
      wdata = alu_result;
    if (mult_en_gated)
      wdata = mult_result;
  end

  assign fwd_o = '{we: rf_we_gated, waddr: id_ex_pipe_i.rf_waddr, wdata: wdata};

  // Fetch only redirects on a live branch
  assign branch_o = '{decision: branch_valid && !kill_ex_i && alu_cmp_result,
                      target:   id_ex_pipe_i.operand_c};

  //////////////////////////////
  // Execution units
  //////////////////////////////

  ex_alu u_alu
  (
    .operator_i   ( id_ex_pipe_i.alu_op    ),
    .operand_a_i  ( id_ex_pipe_i.operand_a ),
    .operand_b_i  ( id_ex_pipe_i.operand_b ),
    .result_o     ( alu_result             ),
    .cmp_result_o ( alu_cmp_result         )
  );

  mult_ctrl u_mult_ctrl
  (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .start_i    ( mult_en_gated ),
    .ex_ready_i ( ex_ready_o    ),
    .last_i     ( mult_last     ),
    .load_o     ( mult_load     ),
    .step_o     ( mult_step     ),
    .ready_o    ( mult_ready    )
  );

  mult_step_counter u_mult_cnt
  (
    .clk    ( clk       ),
    .rst_n  ( rst_n     ),
    .load_i ( mult_load ),
    .step_i ( mult_step ),
    .last_o ( mult_last )
  );

  mult_datapath u_mult_dp
  (
    .clk      ( clk                    ),
    .rst_n    ( rst_n                  ),
    .load_i   ( mult_load              ),
    .step_i   ( mult_step              ),
    .op_i     ( id_ex_pipe_i.mult_op   ),
    .op_a_i   ( id_ex_pipe_i.operand_a ),
    .op_b_i   ( id_ex_pipe_i.operand_b ),
    .result_o ( mult_result            )
  );

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Branches finish here and never wait for writeback
  assign ex_ready_o = (mult_ready && wb_ready_i) || branch_valid;
  assign ex_valid_o = mult_ready && wb_ready_i && id_ex_pipe_i.instr_valid && !kill_ex_i;

  //////////////////////////////
  // EX/WB pipe register
  //////////////////////////////

  // Control bits are flushed when writeback is ready and nothing valid arrives
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_valid_q <= 1'b0;
      wb_we_q    <= 1'b0;
    end
    else if (ex_valid_o)
    begin
      wb_valid_q <= 1'b1;
      wb_we_q    <= rf_we_gated;
    end
    else if (wb_ready_i)
      wb_valid_q <= 1'b0;
  end

  // Payload only moves with a valid result
  always_ff @(posedge clk)
  begin
    if (ex_valid_o)
    begin
      wb_waddr_q <= id_ex_pipe_i.rf_waddr;
      wb_wdata_q <= wdata;
      wb_pc_q    <= id_ex_pipe_i.pc;
    end
  end

  assign ex_wb_pipe_o = '{instr_valid: wb_valid_q, rf_we: wb_we_q, rf_waddr: wb_waddr_q,
                          rf_wdata: wb_wdata_q, pc: wb_pc_q};

endmodule

/* sim/ex_ref_model.svh */
// Execute stage reference model

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// LCG step with a full 32-bit period
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Branch comparison that is false for all other opcodes
function automatic logic ref_cmp(input ex_pkg::alu_op_e op,
                                 input logic [`EX_XLEN-1:0] a,
                                 input logic [`EX_XLEN-1:0] b);
  case (op)
    ex_pkg::ALU_EQ:  return a == b;
    ex_pkg::ALU_NE:  return a != b;
    ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
    ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
    ex_pkg::ALU_LTU: return a < b;
    ex_pkg::ALU_GEU: return a >= b;
    default:         return 1'b0;
  endcase
endfunction

// ALU result with comparisons giving the flag zero-extended
function automatic logic [`EX_XLEN-1:0] ref_alu(input ex_pkg::alu_op_e op,
                                                input logic [`EX_XLEN-1:0] a,
                                                input logic [`EX_XLEN-1:0] b);
  int sh;
  // Only the low shift-amount bits of b count
  sh = b % `EX_XLEN;
  case (op)
    ex_pkg::ALU_ADD:  return a + b;
    ex_pkg::ALU_SUB:  return a - b;
    ex_pkg::ALU_AND:  return a & b;
    ex_pkg::ALU_OR:   return a | b;
    ex_pkg::ALU_XOR:  return a ^ b;
    ex_pkg::ALU_SLL:  return a << sh;
    ex_pkg::ALU_SRL:  return a >> sh;
    ex_pkg::ALU_SRA:  return $signed(a) >>> sh;
    ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
    ex_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
    default:          return ref_cmp(op, a, b) ? 1 : 0;
  endcase
endfunction

// Word of the full 64-bit product
function automatic logic [`EX_XLEN-1:0] ref_mult(input ex_pkg::mult_op_e op,
                                                 input logic [`EX_XLEN-1:0] a,
                                                 input logic [`EX_XLEN-1:0] b);
  logic [2*`EX_XLEN-1:0]        prod_u;
  logic signed [2*`EX_XLEN-1:0] prod_s;
  prod_u = {{`EX_XLEN{1'b0}}, a} * {{`EX_XLEN{1'b0}}, b};
  prod_s = $signed({{`EX_XLEN{a[`EX_XLEN-1]}}, a}) * $signed({{`EX_XLEN{b[`EX_XLEN-1]}}, b});
  case (op)
    ex_pkg::MULT_MULH:  return prod_s[2*`EX_XLEN-1:`EX_XLEN];
    ex_pkg::MULT_MULHU: return prod_u[2*`EX_XLEN-1:`EX_XLEN];
    default:            return prod_u[`EX_XLEN-1:0];
  endcase
endfunction

`endif

/* sim/tb_ex_stage.sv */
// Execute stage testbench

`timescale 1ns/1ps

`include "ex_defs.svh"

module tb_ex_stage;

  localparam int N_ALU    = 200;
  localparam int N_MULT   = 60;
  localparam int N_MIXED  = 80;
  localparam int N_KILL   = 40;
  localparam int N_BRANCH = 40;
  localparam int N_FWD    = 40;
  // Multiplies dominate the run time
  localparam int TIMEOUT_CYCLES = N_ALU + N_MULT * 40 + 2000;
  // Writeback ready modes of the driver
  localparam int WB_HIGH = 0;
  localparam int WB_RAND = 1;
  localparam int WB_LOW  = 2;

  logic                clk;
  logic                rst_n;
  logic                kill_ex_i;
  logic                wb_ready_i;
  logic                ex_ready_o;
  logic                ex_valid_o;
  ex_pkg::id_ex_pipe_t id_ex_pipe_i;
  ex_pkg::ex_wb_pipe_t ex_wb_pipe_o;
  ex_pkg::rf_fwd_t     fwd_o;
  ex_pkg::branch_t     branch_o;

  // Scoreboard and bookkeeping
  ex_pkg::ex_wb_pipe_t exp_q[$];
  ex_pkg::ex_wb_pipe_t exp_rec;
  logic [31:0]         seed;
  logic [`EX_XLEN-1:0] pc_next;
  int                  pass_cnt = 0;
  int                  fail_cnt = 0;
  int                  fwd_cnt = 0;
  int                  cycle_cnt = 0;
  // Previous cycle as seen by the compare process
  logic                prev_wb_ready = 1'b0;
  logic                prev_fwd_valid = 1'b0;
  ex_pkg::rf_fwd_t     prev_fwd;

  `include "ex_ref_model.svh"

  ex_stage u_ex_stage
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .kill_ex_i    ( kill_ex_i    ),
    .id_ex_pipe_i ( id_ex_pipe_i ),
    .wb_ready_i   ( wb_ready_i   ),
    .ex_ready_o   ( ex_ready_o   ),
    .ex_valid_o   ( ex_valid_o   ),
    .ex_wb_pipe_o ( ex_wb_pipe_o ),
    .fwd_o        ( fwd_o        ),
    .branch_o     ( branch_o     )
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Upper halves of two LCG steps
  function automatic logic [31:0] rand_word();
    logic [15:0] hi;
    seed = lcg_next(seed);
    hi   = seed[31:16];
    seed = lcg_next(seed);
    return {hi, seed[31:16]};
  endfunction

  // Biased toward signed corner values
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = rand_word();
    case (r[3:0])
      4'd0:    return 32'h0000_0000;
      4'd1:    return 32'h0000_0001;
      4'd2:    return 32'hffff_ffff;
      4'd3:    return 32'h8000_0000;
      4'd4:    return 32'h7fff_ffff;
      default: return rand_word();
    endcase
  endfunction

  // Fields shared by every instruction kind
  function automatic ex_pkg::id_ex_pipe_t new_instr();
    ex_pkg::id_ex_pipe_t instr;
    instr             = '0;
    instr.instr_valid = 1'b1;
    instr.pc          = pc_next;
    pc_next           = pc_next + 4;
    instr.rf_we       = 1'b1;
    instr.rf_waddr    = `EX_RF_AW'(rand_word());
    instr.operand_a   = rand_word();
    instr.operand_b   = rand_word();
    instr.operand_c   = rand_word();
    return instr;
  endfunction

  function automatic ex_pkg::id_ex_pipe_t alu_instr();
    ex_pkg::id_ex_pipe_t instr;
    instr        = new_instr();
    instr.alu_en = 1'b1;
    instr.alu_op = ex_pkg::alu_op_e'(4'(rand_word()));
    return instr;
  endfunction

  function automatic ex_pkg::id_ex_pipe_t mult_instr();
    ex_pkg::id_ex_pipe_t instr;
    instr           = new_instr();
    instr.mult_en   = 1'b1;
    instr.mult_op   = ex_pkg::mult_op_e'(2'(rand_word() % 3));
    instr.operand_a = pick_operand();
    instr.operand_b = pick_operand();
    return instr;
  endfunction

  // Mostly ALU with one multiply in eight and a random write enable
  function automatic ex_pkg::id_ex_pipe_t mixed_instr();
    ex_pkg::id_ex_pipe_t instr;
    logic [31:0]         r;
    r = rand_word();
    if (r[2:0] == 3'd0)
      instr = mult_instr();
    else
      instr = alu_instr();
    instr.rf_we = r[3];
    return instr;
  endfunction

  function automatic ex_pkg::id_ex_pipe_t branch_instr();
    ex_pkg::id_ex_pipe_t instr;
    instr              = alu_instr();
    instr.rf_we        = 1'b0;
    instr.branch_in_ex = 1'b1;
    instr.alu_op       = ex_pkg::alu_op_e'(4'(10 + rand_word() % 6));
    // Equal operands now and then
    if (instr.operand_c[0])
      instr.operand_b = instr.operand_a;
    return instr;
  endfunction

  // Entry that writeback should see for an instruction
  function automatic ex_pkg::ex_wb_pipe_t expected_wb(input ex_pkg::id_ex_pipe_t instr);
    ex_pkg::ex_wb_pipe_t rec;
    rec.instr_valid = 1'b1;
    rec.rf_we       = instr.rf_we;
    rec.rf_waddr    = instr.rf_waddr;
    rec.pc          = instr.pc;
    if (instr.mult_en)
      rec.rf_wdata = ref_mult(instr.mult_op, instr.operand_a, instr.operand_b);
    else
      rec.rf_wdata = ref_alu(instr.alu_op, instr.operand_a, instr.operand_b);
    return rec;
  endfunction

  task automatic report_mismatch(input string sig, input logic [`EX_XLEN-1:0] exp_val,
                                 input logic [`EX_XLEN-1:0] act_val);
    $display("** Error at %0t: %s expected %h, got %h", $time, sig, exp_val, act_val);
    fail_cnt++;
  endtask

  //////////////////////////////
  // Driver
  //////////////////////////////

  // Starts 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic issue_instr(input ex_pkg::id_ex_pipe_t instr, input logic kill,
                             input int wb_mode);
    logic        accepted;
    logic [31:0] r;
    accepted     = 1'b0;
    id_ex_pipe_i = instr;
    kill_ex_i    = kill;
    while (!accepted)
    begin
      r          = rand_word();
      wb_ready_i = (wb_mode == WB_HIGH) || ((wb_mode == WB_RAND) && r[5]);
      // Inputs and state are settled at the falling edge
      @(negedge clk);
      if (kill && (fwd_o.we || ex_valid_o))
      begin
        $display("Killed instruction at pc %h was forwarded or marked valid", instr.pc);
        fail_cnt++;
      end
      if (ex_ready_o)
      begin
        accepted = 1'b1;
        if (instr.branch_in_ex)
        begin
          if (branch_o.decision !== ref_cmp(instr.alu_op, instr.operand_a, instr.operand_b))
            report_mismatch("branch_o.decision", ref_cmp(instr.alu_op, instr.operand_a,
                            instr.operand_b), branch_o.decision);
          else
            pass_cnt++;
          if (branch_o.target !== instr.operand_c)
            report_mismatch("branch_o.target", instr.operand_c, branch_o.target);
          else
            pass_cnt++;
        end
        else
        begin
          // Other instructions never redirect fetch
          if (branch_o.decision !== 1'b0)
            report_mismatch("branch_o.decision", 1'b0, branch_o.decision);
          else
            pass_cnt++;
          if (!kill)
            exp_q.push_back(expected_wb(instr));
        end
      end
      @(posedge clk);
      #1;
    end
    id_ex_pipe_i.instr_valid = 1'b0;
    kill_ex_i                = 1'b0;
  endtask

  // Let writeback take everything still expected
  task automatic drain_results();
    wb_ready_i = 1'b1;
    while (exp_q.size() != 0)
      @(posedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name, input int fails_before);
    $display("Test %s finished, %0d errors", name, fail_cnt - fails_before);
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      // A valid entry after a ready edge is a new result
      if (prev_wb_ready && ex_wb_pipe_o.instr_valid)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Unexpected result at ex_wb_pipe_o for pc %h at %0t", ex_wb_pipe_o.pc, $time);
          fail_cnt++;
        end
        else
        begin
          exp_rec = exp_q.pop_front();
          if (ex_wb_pipe_o.pc !== exp_rec.pc)
            report_mismatch("ex_wb_pipe_o.pc", exp_rec.pc, ex_wb_pipe_o.pc);
          else
            pass_cnt++;
          if (ex_wb_pipe_o.rf_waddr !== exp_rec.rf_waddr)
            report_mismatch("ex_wb_pipe_o.rf_waddr", exp_rec.rf_waddr, ex_wb_pipe_o.rf_waddr);
          else
            pass_cnt++;
          if (ex_wb_pipe_o.rf_wdata !== exp_rec.rf_wdata)
            report_mismatch("ex_wb_pipe_o.rf_wdata", exp_rec.rf_wdata, ex_wb_pipe_o.rf_wdata);
          else
            pass_cnt++;
          if (ex_wb_pipe_o.rf_we !== exp_rec.rf_we)
            report_mismatch("ex_wb_pipe_o.rf_we", exp_rec.rf_we, ex_wb_pipe_o.rf_we);
          else
            pass_cnt++;
        end
      end
      // Forwarded data must match what was registered
      if (prev_fwd_valid)
      begin
        fwd_cnt++;
        if (ex_wb_pipe_o.rf_waddr !== prev_fwd.waddr)
          report_mismatch("fwd_o.waddr", ex_wb_pipe_o.rf_waddr, prev_fwd.waddr);
        else
          pass_cnt++;
        if (ex_wb_pipe_o.rf_wdata !== prev_fwd.wdata)
          report_mismatch("fwd_o.wdata", ex_wb_pipe_o.rf_wdata, prev_fwd.wdata);
        else
          pass_cnt++;
      end
      prev_wb_ready  = wb_ready_i;
      prev_fwd_valid = ex_valid_o && fwd_o.we;
      prev_fwd       = fwd_o;
    end
  end

  // Run length limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    int fails_before;
    int fwd_before;
    logic [31:0] r;
    seed         = 32'd94360;
    pc_next      = 32'h0000_1000;
    rst_n        = 1'b0;
    kill_ex_i    = 1'b0;
    wb_ready_i   = 1'b0;
    id_ex_pipe_i = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fails_before = fail_cnt;
    repeat (N_ALU) issue_instr(alu_instr(), 1'b0, WB_HIGH);
    drain_results();
    end_test("alu_results", fails_before);

    fails_before = fail_cnt;
    repeat (N_MULT) issue_instr(mult_instr(), 1'b0, WB_HIGH);
    drain_results();
    end_test("mult_results", fails_before);

    fails_before = fail_cnt;
    repeat (N_MIXED) issue_instr(mixed_instr(), 1'b0, WB_RAND);
    drain_results();
    end_test("back_pressure", fails_before);

    // About half of the instructions are killed
    fails_before = fail_cnt;
    repeat (N_KILL)
    begin
      r = rand_word();
      issue_instr(mixed_instr(), r[7], WB_HIGH);
    end
    drain_results();
    end_test("kill", fails_before);

    // Branches must pass while writeback stalls
    fails_before = fail_cnt;
    repeat (N_BRANCH) issue_instr(branch_instr(), 1'b0, WB_LOW);
    drain_results();
    end_test("branches", fails_before);

    fails_before = fail_cnt;
    fwd_before   = fwd_cnt;
    repeat (N_FWD) issue_instr(mixed_instr(), 1'b0, WB_HIGH);
    drain_results();
    if (fwd_cnt == fwd_before)
    begin
      $display("No forwarding cycle was seen in the forwarding test");
      fail_cnt++;
    end
    end_test("forwarding", fails_before);

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
+incdir+sim
common/ex_pkg.sv
alu/ex_alu.sv
mult/mult_ctrl.sv
mult/mult_step_counter.sv
mult/mult_datapath.sv
src/ex_stage.sv
sim/tb_ex_stage.sv
